// ==== Makefile ====
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing --assert -Wall
TOP        = udp_tx_tb
FILELIST   = list.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST PASSED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hdl/ethernet_frame_generator.sv ====
////////////////////////////////////////
// Ethernet frame generator
// Serializes Ethernet, IPv4 and UDP headers,
// payload, zero padding and FCS onto the
// output byte stream
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "udp_tx_cfg.svh"

module ethernet_frame_generator
    import udp_tx_pkg::*;
(
    input   logic                   clock,
    input   logic                   rst,
    input   station_t               station,
    input   logic                   frame_valid_in,
    input   length_t                frame_length,
    input   endpoint_t              frame_endpoint,
    output  logic                   frame_done,
    output  buf_addr_t              rd_addr,
    input   byte_t                  rd_data,
    output  ipv4_fields_t           fields,
    input   udp_port_t              hdr_checksum,
    output  logic                   crc_clear,
    output  logic                   crc_enable,
    output  byte_t                  crc_byte,
    input   logic [`IPV4_W-1:0]     crc,
    output  stream_byte_t           frame,
    output  logic                   frame_valid,
    input   logic                   frame_ready
);

localparam length_t UDP_HDR     = 16'd8;
localparam length_t IP_UDP_HDR  = 16'd28;   // IPv4 plus UDP header

gen_state_t                         state;
length_t                            idx;
length_t                            ident;
station_t                           stn;
length_t                            udp_length;
logic [`HEADER_BYTES*`BYTE_W-1:0]   hdr;
byte_t                              out_data;
logic                               fire;
logic                               pay_last;

assign udp_length = frame_length + UDP_HDR;

// Header in wire order, first byte at the top
assign hdr = {
    frame_endpoint.dst_mac,
    stn.src_mac,
    `ETHERTYPE_IPV4,
    `IPV4_VER_IHL,
    8'h00,
    fields.total_length,
    fields.identification,
    `IPV4_FLAGS_DF,
    `IPV4_TTL,
    `IPV4_PROTO_UDP,
    hdr_checksum,
    fields.src_ip,
    fields.dst_ip,
    stn.src_port,
    frame_endpoint.dst_port,
    udp_length,
    16'h0000                        // UDP checksum unused
};

////////////////////////////////////////
// Output byte select
////////////////////////////////////////
always_comb begin
    case (state)
        HEADER:  out_data = hdr[(`HEADER_BYTES - 1 - idx) * `BYTE_W +: `BYTE_W];
        PAYLOAD: out_data = rd_data;
        FCS:     out_data = crc[idx[1:0] * `BYTE_W +: `BYTE_W];   // LSB first
        default: out_data = '0;
    endcase
end

assign frame_valid = (state == HEADER) || (state == PAYLOAD) ||
                     (state == PAD) || (state == FCS);
assign frame.data  = out_data;
assign frame.last  = (state == FCS) && (idx == length_t'(`FCS_BYTES - 1));
assign fire        = frame_valid && frame_ready;
assign frame_done  = fire && frame.last;
assign pay_last    = (idx == frame_length - 16'd1);

assign crc_clear   = (state == IDLE);
assign crc_enable  = fire && (state != FCS);
assign crc_byte    = out_data;

// Next address already on the RAM when a payload byte leaves
assign rd_addr = (state == PAYLOAD) ? buf_addr_t'(fire ? idx + 16'd1 : idx) : '0;

////////////////////////////////////////
// State machine
////////////////////////////////////////
always_ff @(posedge clock) begin
    if (rst) begin
        state <= IDLE;
        idx   <= '0;
        ident <= '0;
    end else begin
        case (state)
            IDLE: begin
                idx <= '0;
                if (frame_valid_in) begin
                    state <= LOAD;
                end
            end
            LOAD: state <= HEADER;      // Checksum settles
            HEADER: if (fire) begin
                idx <= idx + 16'd1;
                if (idx == length_t'(`HEADER_BYTES - 1)) begin
                    state <= PAYLOAD;
                    idx   <= '0;
                end
            end
            PAYLOAD: if (fire) begin
                idx <= idx + 16'd1;
                if (pay_last) begin
                    if (frame_length < length_t'(`MIN_PAYLOAD)) begin
                        state <= PAD;
                    end else begin
                        state <= FCS;
                        idx   <= '0;
                    end
                end
            end
            PAD: if (fire) begin
                idx <= idx + 16'd1;
                if (idx == length_t'(`MIN_PAYLOAD - 1)) begin
                    state <= FCS;
                    idx   <= '0;
                end
            end
            FCS: if (fire) begin
                idx <= idx + 16'd1;
                if (frame.last) begin
                    state <= IDLE;
                    ident <= ident + 16'd1;
                end
            end
            default: state <= IDLE;
        endcase
    end
end

// Frame constants captured at the request
always_ff @(posedge clock) begin
    if (state == IDLE && frame_valid_in) begin
        stn                   <= station;
        fields.total_length   <= frame_length + IP_UDP_HDR;
        fields.identification <= ident;
        fields.src_ip         <= station.src_ip;
        fields.dst_ip         <= frame_endpoint.dst_ip;
    end
end

endmodule

`default_nettype wire

// ==== hdl/frame_check_sequence.sv ====
////////////////////////////////////////
// Ethernet frame check sequence
// Byte serial CRC-32, reflected polynomial,
// preset to ones and inverted at the output
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "udp_tx_cfg.svh"

module frame_check_sequence
    import udp_tx_pkg::*;
(
    input   logic                   clock,
    input   logic                   rst,
    input   logic                   crc_clear,
    input   logic                   crc_enable,
    input   byte_t                  crc_byte,
    output  logic [`IPV4_W-1:0]     crc
);

logic [`IPV4_W-1:0] crc_reg;

// Eight bit steps, LSB of the byte first
function automatic logic [`IPV4_W-1:0] crc_step(
    input logic [`IPV4_W-1:0]   c_in,
    input byte_t                d
);
    logic [`IPV4_W-1:0] c;
    c = c_in;
    for (int i = 0; i < `BYTE_W; i++) begin
        c = (c >> 1) ^ ({`IPV4_W{c[0] ^ d[i]}} & `CRC_POLY);
    end
    return c;
endfunction

always_ff @(posedge clock) begin
    if (rst || crc_clear) begin
        crc_reg <= '1;
    end else if (crc_enable) begin
        crc_reg <= crc_step(crc_reg, crc_byte);
    end
end

assign crc = ~crc_reg;

endmodule

`default_nettype wire

// ==== hdl/ipv4_header_checksum.sv ====
////////////////////////////////////////
// IPv4 header checksum
// One's complement sum of the ten header
// words, registered in one cycle
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "udp_tx_cfg.svh"

module ipv4_header_checksum
    import udp_tx_pkg::*;
(
    input   logic           clock,
    input   logic           rst,
    input   ipv4_fields_t   fields,
    output  udp_port_t      hdr_checksum
);

logic [19:0]    sum;
logic [16:0]    fold_1;
logic [15:0]    fold_2;

always_comb begin
    sum = 20'({`IPV4_VER_IHL, 8'h00})
        + 20'(fields.total_length)
        + 20'(fields.identification)
        + 20'(`IPV4_FLAGS_DF)
        + 20'({`IPV4_TTL, `IPV4_PROTO_UDP})
        + 20'(16'h0000)                     // Checksum word itself
        + 20'(fields.src_ip[31:16])
        + 20'(fields.src_ip[15:0])
        + 20'(fields.dst_ip[31:16])
        + 20'(fields.dst_ip[15:0]);

    // Second fold cannot carry again
    fold_1 = 17'(sum[15:0]) + 17'(sum[19:16]);
    fold_2 = fold_1[15:0] + 16'(fold_1[16]);
end

always_ff @(posedge clock) begin
    if (rst) begin
        hdr_checksum <= '0;
    end else begin
        hdr_checksum <= ~fold_2;
    end
end

endmodule

`default_nettype wire

// ==== hdl/payload_buffer.sv ====
////////////////////////////////////////
// Payload buffer
// Stores one UDP payload in block RAM, counts
// its length and holds the frame request
// until the generator has sent it
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "udp_tx_cfg.svh"

module payload_buffer
    import udp_tx_pkg::*;
(
    input   logic           clock,
    input   logic           rst,
    input   stream_byte_t   payload,
    input   logic           payload_valid,
    output  logic           payload_ready,
    input   endpoint_t      endpoint,
    output  logic           frame_valid,
    output  length_t        frame_length,
    output  endpoint_t      frame_endpoint,
    input   logic           frame_done,
    input   buf_addr_t      rd_addr,
    output  byte_t          rd_data
);

byte_t      ram [2**`BUF_ADDR_W];
buf_addr_t  wr_addr;
logic       accept;

// Closed while a frame waits or is sent
assign payload_ready = !frame_valid;
assign accept        = payload_valid && payload_ready;

////////////////////////////////////////
// Block RAM
////////////////////////////////////////
always_ff @(posedge clock) begin
    if (accept) begin
        ram[wr_addr] <= payload.data;
    end
    rd_data <= ram[rd_addr];        // One cycle read latency
end

////////////////////////////////////////
// Write address and frame request
////////////////////////////////////////
always_ff @(posedge clock) begin
    if (rst) begin
        wr_addr     <= '0;
        frame_valid <= 1'b0;
    end else if (frame_done) begin
        wr_addr     <= '0;
        frame_valid <= 1'b0;
    end else if (accept) begin
        wr_addr     <= wr_addr + 1'b1;
        frame_valid <= payload.last;
    end
end

// Length and destination of the stored frame
always_ff @(posedge clock) begin
    if (accept && payload.last) begin
        frame_length   <= length_t'(wr_addr) + 16'd1;
        frame_endpoint <= endpoint;
    end
end

endmodule

`default_nettype wire

// ==== hdl/udp_tx_cfg.svh ====
////////////////////////////////////////
// UDP transmit configuration
// Widths, header sizes, protocol constants
// and payload buffer depth
////////////////////////////////////////
`ifndef UDP_TX_CFG_SVH
`define UDP_TX_CFG_SVH

// Field widths
`define BYTE_W          8
`define MAC_W           48
`define IPV4_W          32
`define PORT_W          16
`define BUF_ADDR_W      11

// Frame sizes in bytes
`define MAX_PAYLOAD     1472
`define MIN_PAYLOAD     18      // Pads frame to 64 bytes
`define HEADER_BYTES    42
`define FCS_BYTES       4

// Protocol constants
`define ETHERTYPE_IPV4  16'h0800
`define IPV4_VER_IHL    8'h45
`define IPV4_TTL        8'd64
`define IPV4_PROTO_UDP  8'd17
`define IPV4_FLAGS_DF   16'h4000
`define CRC_POLY        32'hEDB88320

`endif

// ==== hdl/udp_tx_pkg.sv ====
////////////////////////////////////////
// UDP transmit package
// Vector types, stream and address structs,
// frame generator states
////////////////////////////////////////
`default_nettype none

package udp_tx_pkg;

`include "udp_tx_cfg.svh"

typedef logic [`BYTE_W-1:0]     byte_t;
typedef logic [`MAC_W-1:0]      mac_addr_t;
typedef logic [`IPV4_W-1:0]     ipv4_addr_t;
typedef logic [`PORT_W-1:0]     udp_port_t;
typedef logic [`PORT_W-1:0]     length_t;
typedef logic [`BUF_ADDR_W-1:0] buf_addr_t;

// One byte of a stream, last marks end of frame
typedef struct packed {
    logic       last;
    byte_t      data;
} stream_byte_t;

typedef struct packed {
    mac_addr_t  src_mac;
    ipv4_addr_t src_ip;
    udp_port_t  src_port;
} station_t;

typedef struct packed {
    mac_addr_t  dst_mac;
    ipv4_addr_t dst_ip;
    udp_port_t  dst_port;
} endpoint_t;

// Variable part of the IPv4 header
typedef struct packed {
    length_t    total_length;
    length_t    identification;
    ipv4_addr_t src_ip;
    ipv4_addr_t dst_ip;
} ipv4_fields_t;

typedef enum logic [2:0] {IDLE, LOAD, HEADER, PAYLOAD, PAD, FCS} gen_state_t;

endpackage

`default_nettype wire

// ==== hdl/udp_tx_top.sv ====
////////////////////////////////////////
// UDP transmit port
// Payload buffer, frame generator, header
// checksum and FCS on one clock
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "udp_tx_cfg.svh"

module udp_tx_top
    import udp_tx_pkg::*;
(
    input   logic           clock,
    input   logic           rst,
    input   station_t       station,
    input   endpoint_t      endpoint,
    input   stream_byte_t   payload,
    input   logic           payload_valid,
    output  logic           payload_ready,
    output  stream_byte_t   frame,
    output  logic           frame_valid,
    input   logic           frame_ready
);

logic                   req_valid;
length_t                frame_length;
endpoint_t              frame_endpoint;
logic                   frame_done;
buf_addr_t              rd_addr;
byte_t                  rd_data;
ipv4_fields_t           fields;
udp_port_t              hdr_checksum;
logic                   crc_clear;
logic                   crc_enable;
byte_t                  crc_byte;
logic [`IPV4_W-1:0]     crc;

payload_buffer payload_buffer (
    .clock          (clock),
    .rst            (rst),
    .payload        (payload),
    .payload_valid  (payload_valid),
    .payload_ready  (payload_ready),
    .endpoint       (endpoint),
    .frame_valid    (req_valid),
    .frame_length   (frame_length),
    .frame_endpoint (frame_endpoint),
    .frame_done     (frame_done),
    .rd_addr        (rd_addr),
    .rd_data        (rd_data)
);

ethernet_frame_generator ethernet_frame_generator (
    .clock          (clock),
    .rst            (rst),
    .station        (station),
    .frame_valid_in (req_valid),
    .frame_length   (frame_length),
    .frame_endpoint (frame_endpoint),
    .frame_done     (frame_done),
    .rd_addr        (rd_addr),
    .rd_data        (rd_data),
    .fields         (fields),
    .hdr_checksum   (hdr_checksum),
    .crc_clear      (crc_clear),
    .crc_enable     (crc_enable),
    .crc_byte       (crc_byte),
    .crc            (crc),
    .frame          (frame),
    .frame_valid    (frame_valid),
    .frame_ready    (frame_ready)
);

ipv4_header_checksum ipv4_header_checksum (
    .clock          (clock),
    .rst            (rst),
    .fields         (fields),
    .hdr_checksum   (hdr_checksum)
);

frame_check_sequence frame_check_sequence (
    .clock          (clock),
    .rst            (rst),
    .crc_clear      (crc_clear),
    .crc_enable     (crc_enable),
    .crc_byte       (crc_byte),
    .crc            (crc)
);

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+hdl
hdl/udp_tx_pkg.sv
hdl/payload_buffer.sv
hdl/ipv4_header_checksum.sv
hdl/frame_check_sequence.sv
hdl/ethernet_frame_generator.sv
hdl/udp_tx_top.sv
testbench/udp_tx_sva.sv
testbench/udp_tx_tb.sv

// ==== testbench/udp_tx_sva.sv ====
////////////////////////////////////////
// UDP transmit port assertions
// Handshake and payload size checks on
// the top level streams
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "udp_tx_cfg.svh"

module udp_tx_sva
    import udp_tx_pkg::*;
(
    input   logic           clock,
    input   logic           rst,
    input   stream_byte_t   payload,
    input   logic           payload_valid,
    input   logic           payload_ready,
    input   stream_byte_t   frame,
    input   logic           frame_valid,
    input   logic           frame_ready
);

length_t pay_count;     // Bytes of the current payload so far
logic    busy;          // Last payload byte taken, frame not yet out

always_ff @(posedge clock) begin
    if (rst) begin
        pay_count <= '0;
    end else if (payload_valid && payload_ready) begin
        pay_count <= payload.last ? '0 : pay_count + 16'd1;
    end
end

always_ff @(posedge clock) begin
    if (rst) begin
        busy <= 1'b0;
    end else if (payload_valid && payload_ready && payload.last) begin
        busy <= 1'b1;
    end else if (frame_valid && frame_ready && frame.last) begin
        busy <= 1'b0;
    end
end

frame_idle_after_reset: assert property (@(posedge clock) rst |=> !frame_valid)
    else $error("frame_valid high after reset");

frame_hold: assert property (@(posedge clock) disable iff (rst)
    (frame_valid && !frame_ready) |=> (frame_valid && $stable(frame)))
    else $error("frame byte changed while stalled");

// Buffer stays closed until the final frame byte has moved
no_accept_when_busy: assert property (@(posedge clock) disable iff (rst)
    busy |-> !payload_ready)
    else $error("payload_ready high while a frame is pending");

payload_size: assert property (@(posedge clock) disable iff (rst)
    (payload_valid && payload_ready) |-> (pay_count < length_t'(`MAX_PAYLOAD)))
    else $error("payload longer than the maximum");

endmodule

bind udp_tx_top udp_tx_sva sva (
    .clock          (clock),
    .rst            (rst),
    .payload        (payload),
    .payload_valid  (payload_valid),
    .payload_ready  (payload_ready),
    .frame          (frame),
    .frame_valid    (frame_valid),
    .frame_ready    (frame_ready)
);

`default_nettype wire

// ==== testbench/udp_tx_tb.sv ====
////////////////////////////////////////
// UDP transmit port testbench
// Directed frame tests against a software
// model of headers, padding and FCS
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "udp_tx_cfg.svh"

module udp_tx_tb
    import udp_tx_pkg::*;
();

logic           clock;
logic           rst;
station_t       station;
endpoint_t      endpoint;
stream_byte_t   payload;
logic           payload_valid;
logic           payload_ready;
stream_byte_t   frame;
logic           frame_valid;
logic           frame_ready;

byte_t          pay[$];         // Payload of the current frame
byte_t          exp_bytes[$];   // Model frame without last flags
stream_byte_t   rx[$];          // Received frame
length_t        next_ident;
int             len_random;
int             timeout_cycles;

udp_tx_top UUT (.*);

initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
end

////////////////////////////////////////
// Error reporting
////////////////////////////////////////
task automatic end_in_failure();
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped on the first error");
endtask

task automatic report_error(input string msg);
    $display("%s", msg);
    end_in_failure();
endtask

task automatic report_mismatch(input string name, input string what,
                               input logic [31:0] exp_val, input logic [31:0] act_val);
    $display("[ERROR] %s: %s expected %0h, actual %0h", name, what, exp_val, act_val);
    end_in_failure();
endtask

////////////////////////////////////////
// Reference frame model
////////////////////////////////////////
function automatic int frame_bytes(input int n);
    return `HEADER_BYTES + ((n > `MIN_PAYLOAD) ? n : `MIN_PAYLOAD) + `FCS_BYTES;
endfunction

// Standard reflected CRC-32 over the model frame
function automatic logic [31:0] crc32();
    logic [31:0] c;
    c = 32'hFFFF_FFFF;
    foreach (exp_bytes[i]) begin
        c = c ^ {24'h0, exp_bytes[i]};
        for (int b = 0; b < 8; b++) begin
            c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
        end
    end
    return ~c;
endfunction

task automatic push_field(input logic [47:0] value, input int count);
    for (int i = count - 1; i >= 0; i--) begin
        exp_bytes.push_back(value[i*8 +: 8]);
    end
endtask

task automatic build_frame(input endpoint_t ep);
    logic [31:0]    sum;
    logic [31:0]    fcs;
    int             n;
    n = pay.size();
    exp_bytes.delete();
    push_field(ep.dst_mac, 6);
    push_field(station.src_mac, 6);
    push_field(48'h0800, 2);
    push_field(48'h4500, 2);
    push_field(48'(n + 28), 2);
    push_field(48'(next_ident), 2);
    push_field(48'h4000, 2);            // Don't fragment
    push_field(48'h4011, 2);            // TTL 64, UDP
    push_field(48'h0, 2);
    push_field(48'(station.src_ip), 4);
    push_field(48'(ep.dst_ip), 4);
    push_field(48'(station.src_port), 2);
    push_field(48'(ep.dst_port), 2);
    push_field(48'(n + 8), 2);
    push_field(48'h0, 2);
    foreach (pay[i]) begin
        exp_bytes.push_back(pay[i]);
    end
    while (exp_bytes.size() < `HEADER_BYTES + `MIN_PAYLOAD) begin
        exp_bytes.push_back(8'h00);
    end
    // IPv4 header sits at bytes 14 to 33
    sum = '0;
    for (int i = 14; i < 34; i += 2) begin
        sum = sum + {16'h0, exp_bytes[i], exp_bytes[i+1]};
    end
    while (sum[31:16] != 16'h0) begin
        sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
    end
    exp_bytes[24] = ~sum[15:8];
    exp_bytes[25] = ~sum[7:0];
    fcs = crc32();
    for (int i = 0; i < 4; i++) begin
        exp_bytes.push_back(fcs[i*8 +: 8]);     // LSB first
    end
endtask

////////////////////////////////////////
// Stimulus and collection
////////////////////////////////////////
task automatic apply_reset();
    @(negedge clock);
    rst           = 1'b1;
    payload_valid = 1'b0;
    repeat (2) @(negedge clock);
    rst        = 1'b0;
    next_ident = '0;
endtask

task automatic send_payload(input endpoint_t ep);
    int i;
    i = 0;
    @(negedge clock);
    endpoint = ep;
    while (i < pay.size()) begin
        payload.data  = pay[i];
        payload.last  = (i == pay.size() - 1);
        payload_valid = 1'b1;
        #1;
        if (payload_ready) begin
            i++;
        end
        @(negedge clock);
    end
    payload_valid = 1'b0;
    payload       = '0;
endtask

task automatic collect_frame(input string name, input bit toggle);
    stream_byte_t   got;
    stream_byte_t   exp_byte;
    int             n;
    bit             done;
    n    = 0;
    done = 1'b0;
    rx.delete();
    while (!done) begin
        @(negedge clock);
        frame_ready = toggle ? 1'($urandom % 2) : 1'b1;
        #1;
        assert (!payload_ready)
            else report_error({name, ": payload_ready rose before the frame was sent"});
        if (frame_valid && frame_ready) begin
            got = frame;
            assert (n < exp_bytes.size())
                else report_error({name, ": frame runs past its expected length"});
            exp_byte = {1'(n == exp_bytes.size() - 1), exp_bytes[n]};
            assert (got == exp_byte)
                else report_mismatch(name, $sformatf("byte %0d", n), 32'(exp_byte), 32'(got));
            rx.push_back(got);
            n++;
            done = got.last;
        end
    end
    @(negedge clock);
    #1;
    assert (payload_ready)
        else report_error({name, ": payload_ready stayed low after the frame"});
endtask

task automatic run_frame(input string name, input int n, input bit toggle);
    endpoint_t ep;
    ep = {$urandom, $urandom, $urandom};
    pay.delete();
    repeat (n) pay.push_back(byte_t'($urandom));
    build_frame(ep);
    send_payload(ep);
    collect_frame(name, toggle);
    next_ident++;
endtask

task automatic check_field(input string name, input string what, input int pos,
                           input logic [15:0] exp_val);
    logic [15:0] act;
    act = {rx[pos].data, rx[pos+1].data};
    assert (act == exp_val) else report_mismatch(name, what, 32'(exp_val), 32'(act));
endtask

////////////////////////////////////////
// Directed tests
////////////////////////////////////////
task automatic test_short_payload();
    run_frame("short_payload", 5, 1'b0);
    assert (rx.size() == 64)
        else report_mismatch("short_payload", "frame length", 32'd64, 32'(rx.size()));
endtask

task automatic test_random_payload();
    run_frame("random_payload", 200, 1'b0);
    check_field("random_payload", "IPv4 total length", 16, 16'd228);
    check_field("random_payload", "UDP length", 38, 16'd208);
endtask

task automatic test_back_pressure();
    run_frame("back_pressure", len_random, 1'b1);
endtask

task automatic test_back_to_back();
    apply_reset();
    for (int k = 0; k < 3; k++) begin
        run_frame("back_to_back", 10 + 25 * k, 1'b0);
        check_field("back_to_back", "identification", 18, 16'(k));
    end
endtask

task automatic test_max_payload();
    run_frame("max_payload", `MAX_PAYLOAD, 1'b0);
    assert (rx.size() == 1518)
        else report_mismatch("max_payload", "frame length", 32'd1518, 32'(rx.size()));
endtask

initial begin
    void'($urandom(32'hfaf4));
    rst           = 1'b1;
    station       = {48'h02_00_5E_10_00_01, 32'hC0A8_0A01, 16'd5000};
    endpoint      = '0;
    payload       = '0;
    payload_valid = 1'b0;
    frame_ready   = 1'b0;
    next_ident    = '0;
    len_random    = 50 + int'($urandom % 200);
    timeout_cycles = 4 * (frame_bytes(5) + frame_bytes(200) + frame_bytes(len_random)
                   + frame_bytes(10) + frame_bytes(35) + frame_bytes(60)
                   + frame_bytes(`MAX_PAYLOAD)) + 500;
    apply_reset();
    test_short_payload();
    test_random_payload();
    test_back_pressure();
    test_back_to_back();
    test_max_payload();
    $display("TEST PASSED");
    $finish;
end

// Watchdog
initial begin
    wait (timeout_cycles > 0);
    repeat (timeout_cycles) @(posedge clock);
    report_error("The run timed out before all tests finished");
end

endmodule

`default_nettype wire
